// File: vlog.f
+incdir+include
rtl/cache_pkg.sv
rtl/cache_bank_if.sv
rtl/sram_bank.sv
rtl/dcache_ctrl.sv
rtl/line_merge.sv
rtl/dcache_top.sv
verification/tb_dcache_top.sv

// File: Makefile
# Verilator build and run of the data cache testbench

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache_top \
		-f vlog.f -Mdir obj_dir -o sim_dcache
	@out="$$(./obj_dir/sim_dcache 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: include/tb_mem_model.svh
// testbench memory model, initial data rule and coherent cpu word model
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// keyed by word address, a missing entry still holds its initial data
logic [cache_pkg::WORD_W-1:0] mem_model [logic [cache_pkg::ADDR_W-1:0]];   // dut write-backs only
logic [cache_pkg::WORD_W-1:0] coh_model [logic [cache_pkg::ADDR_W-1:0]];   // every cpu write

function automatic logic [cache_pkg::ADDR_W-1:0] word_addr(
    input logic [cache_pkg::ADDR_W-1:0] addr
);
    return {addr[cache_pkg::ADDR_W-1:3], 3'b000};
endfunction

// untouched memory: address times a fixed odd constant
function automatic logic [cache_pkg::WORD_W-1:0] init_word(
    input logic [cache_pkg::ADDR_W-1:0] addr
);
    logic [cache_pkg::WORD_W-1:0] a;
    a = word_addr(addr);
    return a * 64'h0000_0000_9e37_79b9;
endfunction

function automatic logic [cache_pkg::WORD_W-1:0] mem_word(
    input logic [cache_pkg::ADDR_W-1:0] addr
);
    logic [cache_pkg::ADDR_W-1:0] wa;
    wa = word_addr(addr);
    return mem_model.exists(wa) ? mem_model[wa] : init_word(wa);
endfunction

function automatic logic [cache_pkg::WORD_W-1:0] coh_word(
    input logic [cache_pkg::ADDR_W-1:0] addr
);
    logic [cache_pkg::ADDR_W-1:0] wa;
    wa = word_addr(addr);
    return coh_model.exists(wa) ? coh_model[wa] : init_word(wa);
endfunction

// line views, low word at the aligned address
function automatic cache_pkg::line_t mem_line(input logic [cache_pkg::ADDR_W-1:0] addr);
    cache_pkg::line_t l;
    l.words[0] = mem_word(addr);
    l.words[1] = mem_word(addr + 8);
    return l;
endfunction

function automatic cache_pkg::line_t coh_line(input logic [cache_pkg::ADDR_W-1:0] addr);
    cache_pkg::line_t l;
    l.words[0] = coh_word(addr);
    l.words[1] = coh_word(addr + 8);
    return l;
endfunction

function automatic void mem_store_line(
    input logic [cache_pkg::ADDR_W-1:0] addr,
    input cache_pkg::line_t             line
);
    mem_model[word_addr(addr)]     = line.words[0];
    mem_model[word_addr(addr + 8)] = line.words[1];
endfunction

function automatic void coh_store(
    input logic [cache_pkg::ADDR_W-1:0] addr,
    input logic [cache_pkg::WORD_W-1:0] data,
    input logic [cache_pkg::MASK_W-1:0] mask
);
    logic [cache_pkg::WORD_W-1:0] w;
    w = coh_word(addr);
    for (int i = 0; i < cache_pkg::MASK_W; i++) begin
        if (mask[i]) w[8*i +: 8] = data[8*i +: 8];
    end
    coh_model[word_addr(addr)] = w;
endfunction

`endif

// File: verification/tb_dcache_top.sv
// data cache testbench with clock, reset, random cpu traffic, memory responder and checks
`timescale 1ns/1ns

module tb_dcache_top;

    localparam logic [31:0] SEED          = 32'hcf7a_f82c;
    localparam int          REQ_TIMEOUT   = 60;
    localparam int          FLUSH_TIMEOUT = 2000;
    localparam int          ROUNDS        = 4;
    localparam int          OPS_PER_ROUND = 400;
    localparam int          HIT_CYCLES    = 4;   // ready 3 edges after drive, seen one edge later

    logic                             clk;
    logic                             rst;
    logic [cache_pkg::ADDR_W-1:0]     cpu_addr_i;
    logic                             cpu_we_i;
    logic                             cpu_valid_i;
    logic [cache_pkg::WORD_W-1:0]     cpu_wdata_i;
    logic [cache_pkg::MASK_W-1:0]     cpu_wmask_i;
    logic [cache_pkg::WORD_W-1:0]     cpu_rdata_o;
    logic                             cpu_ready_o;
    logic                             cache_idle_o;
    logic                             flush_i;
    logic [cache_pkg::ADDR_W-1:0]     mem_addr_o;
    logic                             mem_we_o;
    logic                             mem_valid_o;
    logic [cache_pkg::LINE_W-1:0]     mem_wdata_o;
    logic [cache_pkg::LINE_W-1:0]     mem_rdata_i;
    logic                             mem_ready_i;

    `include "tb_mem_model.svh"

    bit          dirty_lines [logic [31:0]];   // lines with cpu data not yet in memory
    logic [31:0] res_line [logic [7:0]];       // line address resident at each index
    logic        log_we [$];                   // memory transfers seen since last clear
    logic [31:0] log_addr [$];

    dcache_top u_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s got %0h expected %0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] random_addr();
        logic [7:0]  idx;
        logic [19:0] tag;
        logic [3:0]  offs;
        idx  = 8'($urandom_range(3, 0) * 64 + $urandom_range(3, 0));   // four rows per bank
        tag  = 20'h000a5 + 20'($urandom_range(2, 0));                   // three tags per index
        offs = 4'($urandom_range(15, 0));
        return {tag, idx, offs};
    endfunction

    // one memory transfer completes here, in the ready cycle
    task automatic serve_transfer();
        log_we.push_back(mem_we_o);
        log_addr.push_back(mem_addr_o);
        check("mem_addr_o offset", mem_addr_o[3:0], 4'h0);
        if (mem_we_o) begin
            if (!dirty_lines.exists(mem_addr_o)) begin
                abort_run("a line without unwritten cpu data was written back");
            end
            check("mem_wdata_o", mem_wdata_o, coh_line(mem_addr_o));
            mem_store_line(mem_addr_o, mem_wdata_o);
            dirty_lines.delete(mem_addr_o);
        end else begin
            mem_rdata_i <= mem_line(mem_addr_o);
        end
    endtask

    initial begin : mem_responder
        int   delay;
        logic busy;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        delay       = 0;
        busy        = 1'b0;
        forever begin
            @(posedge clk);
            mem_ready_i <= 1'b0;
            if (!busy) begin
                if (mem_valid_o && !mem_ready_i) begin   // skip the cycle of the last pulse
                    busy  = 1'b1;
                    delay = $urandom_range(6, 0);
                end
            end else if (delay > 0) begin
                delay--;
            end else begin
                busy = 1'b0;
                serve_transfer();
                mem_ready_i <= 1'b1;
            end
        end
    end

    task automatic cpu_access(input logic [31:0] addr, input logic we,
                              input logic [63:0] wdata, input logic [7:0] wmask);
        logic [31:0] la;
        logic [7:0]  idx;
        logic        exp_we [$];
        logic [31:0] exp_addr [$];
        int          cycles;
        la  = {addr[31:4], 4'h0};
        idx = addr[11:4];
        log_we.delete();
        log_addr.delete();
        if (!(res_line.exists(idx) && res_line[idx] == la)) begin
            if (res_line.exists(idx) && dirty_lines.exists(res_line[idx])) begin
                exp_we.push_back(1'b1);   // dirty victim goes out first
                exp_addr.push_back(res_line[idx]);
            end
            exp_we.push_back(1'b0);
            exp_addr.push_back(la);
            res_line[idx] = la;
        end
        @(posedge clk);
        cpu_addr_i  <= addr;
        cpu_we_i    <= we;
        cpu_wdata_i <= wdata;
        cpu_wmask_i <= wmask;
        cpu_valid_i <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) abort_run("cpu request got no ready within the timeout");
        end while (!cpu_ready_o);
        cpu_valid_i <= 1'b0;
        if (!we) check("cpu_rdata_o", cpu_rdata_o, coh_word(addr));
        check("memory transfer count", log_we.size(), exp_we.size());
        foreach (exp_we[i]) begin
            check("mem_we_o", log_we[i], exp_we[i]);
            check("mem_addr_o", log_addr[i], exp_addr[i]);
        end
        if (exp_we.size() == 0) check("hit latency", cycles, HIT_CYCLES);
        if (we) begin
            coh_store(addr, wdata, wmask);
            dirty_lines[la] = 1'b1;
        end
    endtask

    task automatic flush_cache();
        int n_dirty;
        int cycles;
        n_dirty = dirty_lines.num();
        log_we.delete();
        log_addr.delete();
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) abort_run("cache did not become idle before the flush");
        end while (!cache_idle_o);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > FLUSH_TIMEOUT) abort_run("flush did not finish within the timeout");
        end while (!cache_idle_o);
        check("flush write-back count", log_we.size(), n_dirty);
        foreach (log_we[i]) check("mem_we_o", log_we[i], 1'b1);
        foreach (coh_model[a]) check("memory word", mem_word(a), coh_model[a]);
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] last_addr;
        logic        we;
        rst         = 1'b1;
        cpu_addr_i  = '0;
        cpu_we_i    = 1'b0;
        cpu_valid_i = 1'b0;
        cpu_wdata_i = '0;
        cpu_wmask_i = '0;
        flush_i     = 1'b0;
        addr        = '0;
        last_addr   = '0;
        we          = 1'b0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("cache_idle_o", cache_idle_o, 1'b1);
        check("cpu_ready_o", cpu_ready_o, 1'b0);
        check("mem_valid_o", mem_valid_o, 1'b0);
        for (int round = 0; round < ROUNDS; round++) begin
            for (int n = 0; n < OPS_PER_ROUND; n++) begin
                if (n > 0 && $urandom_range(3, 0) == 0) begin
                    cpu_access(last_addr, 1'b0, '0, '0);   // repeat read of the line just used
                end else begin
                    addr = random_addr();
                    we   = 1'($urandom_range(1, 0));
                    cpu_access(addr, we, {$urandom, $urandom}, 8'($urandom_range(255, 1)));
                    last_addr = addr;
                end
            end
            flush_cache();
            flush_cache();   // nothing left dirty
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: rtl/dcache_top.sv
// data cache top level: bank interfaces, sram banks, controller and merge block
`timescale 1ns/1ns

module dcache_top (
    input  logic                             clk,
    input  logic                             rst,
    // cpu side
    input  logic [cache_pkg::ADDR_W-1:0]     cpu_addr_i,
    input  logic                             cpu_we_i,
    input  logic                             cpu_valid_i,
    input  logic [cache_pkg::WORD_W-1:0]     cpu_wdata_i,
    input  logic [cache_pkg::MASK_W-1:0]     cpu_wmask_i,
    output logic [cache_pkg::WORD_W-1:0]     cpu_rdata_o,
    output logic                             cpu_ready_o,
    output logic                             cache_idle_o,
    input  logic                             flush_i,
    // memory side
    output logic [cache_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic                             mem_we_o,
    output logic                             mem_valid_o,
    output logic [cache_pkg::LINE_W-1:0]     mem_wdata_o,
    input  logic [cache_pkg::LINE_W-1:0]     mem_rdata_i,
    input  logic                             mem_ready_i
);

    logic [cache_pkg::INDEX_W-cache_pkg::ROW_W-1:0] bank_sel;
    logic                                         word_sel;
    logic [cache_pkg::WORD_W-1:0]                 rd_word;
    cache_pkg::line_t                             merged_line;
    cache_pkg::line_t                             victim_line;

    cache_bank_if bank_if [cache_pkg::NUM_BANKS] ();

    for (genvar b = 0; b < cache_pkg::NUM_BANKS; b++) begin : g_bank
        sram_bank u_sram_bank (
            .clk  (clk),
            .rst  (rst),
            .bank (bank_if[b])
        );
    end

    dcache_ctrl u_dcache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_valid_i   (cpu_valid_i),
        .cpu_wmask_i   (cpu_wmask_i),
        .flush_i       (flush_i),
        .cpu_rdata_o   (cpu_rdata_o),
        .cpu_ready_o   (cpu_ready_o),
        .cache_idle_o  (cache_idle_o),
        .mem_addr_o    (mem_addr_o),
        .mem_we_o      (mem_we_o),
        .mem_valid_o   (mem_valid_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ready_i   (mem_ready_i),
        .bank_sel_o    (bank_sel),
        .word_sel_o    (word_sel),
        .rd_word_i     (rd_word),
        .merged_line_i (merged_line),
        .victim_line_i (victim_line),
        .banks         (bank_if)
    );

    line_merge u_line_merge (
        .bank_sel_i    (bank_sel),
        .word_sel_i    (word_sel),
        .cpu_wdata_i   (cpu_wdata_i),
        .cpu_wmask_i   (cpu_wmask_i),
        .banks         (bank_if),
        .rd_word_o     (rd_word),
        .merged_line_o (merged_line),
        .victim_line_o (victim_line)
    );

endmodule

// File: rtl/line_merge.sv
// bank output select, read word extract, masked write merge and victim line
`timescale 1ns/1ns

module line_merge (
    input  logic [cache_pkg::INDEX_W-cache_pkg::ROW_W-1:0] bank_sel_i,
    input  logic                                         word_sel_i,
    input  logic [cache_pkg::WORD_W-1:0]                 cpu_wdata_i,
    input  logic [cache_pkg::MASK_W-1:0]                 cpu_wmask_i,
    cache_bank_if.drain_mp                               banks [cache_pkg::NUM_BANKS],
    output logic [cache_pkg::WORD_W-1:0]                 rd_word_o,
    output cache_pkg::line_t                             merged_line_o,
    output cache_pkg::line_t                             victim_line_o
);

    cache_pkg::line_t bank_rd [cache_pkg::NUM_BANKS];

    for (genvar b = 0; b < cache_pkg::NUM_BANKS; b++) begin : g_bank_rd
        assign bank_rd[b] = banks[b].rdata;
    end

    // same line feeds the read, the merge and the write-back
    assign victim_line_o = bank_rd[bank_sel_i];
    assign rd_word_o     = victim_line_o.words[word_sel_i];

    always_comb begin
        merged_line_o = victim_line_o;
        for (int i = 0; i < cache_pkg::MASK_W; i++) begin
            if (cpu_wmask_i[i]) begin
                // byte i of the addressed half
                merged_line_o.bytes[int'(word_sel_i) * cache_pkg::MASK_W + i] =
                    cpu_wdata_i[8*i +: 8];
            end
        end
    end

endmodule

// File: rtl/dcache_ctrl.sv
// cache controller fsm, valid/dirty/tag arrays, flush counter, memory port and cpu response
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    // cpu side
    input  logic [cache_pkg::ADDR_W-1:0]                 cpu_addr_i,
    input  logic                                         cpu_we_i,
    input  logic                                         cpu_valid_i,
    input  logic [cache_pkg::MASK_W-1:0]                 cpu_wmask_i,
    input  logic                                         flush_i,
    output logic [cache_pkg::WORD_W-1:0]                 cpu_rdata_o,
    output logic                                         cpu_ready_o,
    output logic                                         cache_idle_o,
    // memory side
    output logic [cache_pkg::ADDR_W-1:0]                 mem_addr_o,
    output logic                                         mem_we_o,
    output logic                                         mem_valid_o,
    output cache_pkg::line_t                             mem_wdata_o,
    input  cache_pkg::line_t                             mem_rdata_i,
    input  logic                                         mem_ready_i,
    // merge block
    output logic [cache_pkg::INDEX_W-cache_pkg::ROW_W-1:0] bank_sel_o,
    output logic                                         word_sel_o,
    input  logic [cache_pkg::WORD_W-1:0]                 rd_word_i,
    input  cache_pkg::line_t                             merged_line_i,
    input  cache_pkg::line_t                             victim_line_i,
    cache_bank_if.ctrl_mp                                banks [cache_pkg::NUM_BANKS]
);

    cache_pkg::state_t state_q;
    cache_pkg::state_t state_d;

    logic [2**cache_pkg::INDEX_W-1:0] valid_q;
    logic [2**cache_pkg::INDEX_W-1:0] dirty_q;
    logic [cache_pkg::TAG_W-1:0]      tag_q [2**cache_pkg::INDEX_W];

    logic [cache_pkg::INDEX_W-1:0]   flush_idx_q;
    logic [cache_pkg::INDEX_W-1:0]   cpu_index;
    logic [cache_pkg::INDEX_W-1:0]   line_idx;
    logic [cache_pkg::TAG_W-1:0]     cpu_tag;
    logic [cache_pkg::NUM_BANKS-1:0] wen_vec;

    logic flushing;
    logic flush_last;
    logic hit;
    logic victim_dirty;
    logic mem_done;
    logic mem_start;
    logic fill_done;

    assign cpu_index = cpu_addr_i[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign cpu_tag   = cpu_addr_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];

    assign flushing   = (state_q == cache_pkg::FLUSH_READ) || (state_q == cache_pkg::FLUSH_WB);
    assign flush_last = &flush_idx_q;
    assign line_idx   = flushing ? flush_idx_q : cpu_index;   // flush walks every index

    assign hit          = valid_q[cpu_index] && (tag_q[cpu_index] == cpu_tag);
    assign victim_dirty = valid_q[line_idx] && dirty_q[line_idx];

    assign mem_done  = mem_valid_o && mem_ready_i;
    assign fill_done = (state_q == cache_pkg::ALLOCATE) && mem_done;
    assign mem_start = !mem_valid_o && ((state_q == cache_pkg::ALLOCATE) ||
                                        (state_q == cache_pkg::WRITEBACK) ||
                                        (state_q == cache_pkg::FLUSH_WB));

    assign bank_sel_o   = line_idx[cache_pkg::INDEX_W-1:cache_pkg::ROW_W];
    assign word_sel_o   = cpu_addr_i[cache_pkg::OFFSET_W-1];
    assign cache_idle_o = (state_q == cache_pkg::IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::IDLE: begin
                // a request still up during its ready cycle is already served
                if (cpu_valid_i && !cpu_ready_o) begin
                    state_d = cache_pkg::COMPARE;
                end else if (flush_i) begin
                    state_d = cache_pkg::FLUSH_READ;
                end
            end
            cache_pkg::COMPARE: begin
                if (hit) begin
                    state_d = cache_pkg::READIN;
                end else if (victim_dirty) begin
                    state_d = cache_pkg::WRITEBACK;
                end else begin
                    state_d = cache_pkg::ALLOCATE;
                end
            end
            cache_pkg::ALLOCATE: begin
                if (mem_done) state_d = cache_pkg::COMPARE;   // retry as a hit
            end
            cache_pkg::WRITEBACK: begin
                if (mem_done) state_d = cache_pkg::ALLOCATE;
            end
            cache_pkg::READIN: begin
                state_d = cpu_we_i ? cache_pkg::WRITEIN : cache_pkg::IDLE;
            end
            cache_pkg::WRITEIN: begin
                state_d = cache_pkg::IDLE;
            end
            cache_pkg::FLUSH_READ: begin
                if (victim_dirty) begin
                    state_d = cache_pkg::FLUSH_WB;
                end else if (flush_last) begin
                    state_d = cache_pkg::IDLE;
                end
            end
            cache_pkg::FLUSH_WB: begin
                if (mem_done) begin
                    state_d = flush_last ? cache_pkg::IDLE : cache_pkg::FLUSH_READ;
                end
            end
            default: state_d = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= cache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flush_idx_q <= '0;
        end else if (state_q == cache_pkg::IDLE && state_d == cache_pkg::FLUSH_READ) begin
            flush_idx_q <= '0;
        end else if ((state_q == cache_pkg::FLUSH_READ && !victim_dirty) ||
                     (state_q == cache_pkg::FLUSH_WB && mem_done)) begin
            flush_idx_q <= flush_idx_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_done) begin
                valid_q[cpu_index] <= 1'b1;
                dirty_q[cpu_index] <= 1'b0;
            end
            if (state_q == cache_pkg::WRITEIN && |cpu_wmask_i) begin
                dirty_q[cpu_index] <= 1'b1;
            end
            if (state_q == cache_pkg::FLUSH_WB && mem_done) begin
                dirty_q[flush_idx_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) tag_q[cpu_index] <= cpu_tag;
    end

    // memory port carries one transfer at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid_o <= 1'b0;
        end else if (mem_done) begin
            mem_valid_o <= 1'b0;
        end else if (mem_start) begin
            mem_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            mem_we_o    <= (state_q != cache_pkg::ALLOCATE);
            mem_wdata_o <= victim_line_i;
            if (state_q == cache_pkg::ALLOCATE) begin
                mem_addr_o <= {cpu_addr_i[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                               {cache_pkg::OFFSET_W{1'b0}}};
            end else begin
                // victim address rebuilt from the stored tag
                mem_addr_o <= {tag_q[line_idx], line_idx, {cache_pkg::OFFSET_W{1'b0}}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_ready_o <= 1'b0;
        end else begin
            cpu_ready_o <= (state_q == cache_pkg::READIN);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::READIN && !cpu_we_i) cpu_rdata_o <= rd_word_i;
    end

    for (genvar b = 0; b < cache_pkg::NUM_BANKS; b++) begin : g_bank_drive
        assign wen_vec[b] = (int'(bank_sel_o) == b) &&
                            (fill_done || state_q == cache_pkg::WRITEIN);
        assign banks[b].row   = line_idx[cache_pkg::ROW_W-1:0];
        assign banks[b].wen   = wen_vec[b];
        assign banks[b].wdata = (state_q == cache_pkg::WRITEIN) ? merged_line_i : mem_rdata_i;
    end

    // a cpu write only lands in a line that holds its tag
    a_write_on_hit: assert property (
        @(posedge clk) disable iff (rst) (state_q == cache_pkg::WRITEIN) |-> hit
    );

    a_mem_valid_held: assert property (
        @(posedge clk) disable iff (rst) mem_valid_o && !mem_ready_i |=> mem_valid_o
    );

    a_ready_single: assert property (
        @(posedge clk) disable iff (rst) cpu_ready_o |=> !cpu_ready_o
    );

endmodule

// File: rtl/sram_bank.sv
// 64 row by 128 bit single-port synchronous sram bank with registered read
`timescale 1ns/1ns

module sram_bank (
    input logic           clk,
    input logic           rst,
    cache_bank_if.bank_mp bank
);

    cache_pkg::line_t mem_q [2**cache_pkg::ROW_W];

    always_ff @(posedge clk) begin
        if (bank.wen) begin
            mem_q[bank.row] <= bank.wdata;
        end
        bank.rdata <= mem_q[bank.row];   // old contents on a write cycle
    end

    // a write to an unknown row would corrupt an arbitrary line
    a_row_known: assert property (
        @(posedge clk) disable iff (rst)
        bank.wen |-> !$isunknown(bank.row)
    );

endmodule

// File: rtl/cache_bank_if.sv
// interface for one data bank with controller, bank and drain modports
`timescale 1ns/1ns

interface cache_bank_if;

    logic [cache_pkg::ROW_W-1:0] row;
    logic                        wen;     // active high, one bank at a time
    cache_pkg::line_t            wdata;
    cache_pkg::line_t            rdata;   // registered, one cycle after row

    modport ctrl_mp (
        output row,
        output wen,
        output wdata
    );

    modport bank_mp (
        input  row,
        input  wen,
        input  wdata,
        output rdata
    );

    modport drain_mp (
        input rdata
    );

endinterface

// File: rtl/cache_pkg.sv
// address field widths, cache line union and controller state encoding
package cache_pkg;

    // address split: tag | index | offset
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    // storage geometry
    localparam int NUM_BANKS = 4;
    localparam int ROW_W     = 6;    // rows per bank, low index bits
    localparam int LINE_W    = 128;
    localparam int WORD_W    = 64;
    localparam int MASK_W    = 8;    // one bit per cpu byte

    localparam int LINE_WORDS = LINE_W / WORD_W;
    localparam int LINE_BYTES = LINE_W / 8;

    // one line, read either as cpu words or as bytes
    typedef union packed {
        logic [LINE_WORDS-1:0][WORD_W-1:0] words;   // word select on read
        logic [LINE_BYTES-1:0][7:0]        bytes;   // masked merge on write
    } line_t;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        COMPARE    = 3'd1,
        ALLOCATE   = 3'd2,
        READIN     = 3'd3,
        WRITEBACK  = 3'd4,
        WRITEIN    = 3'd5,
        FLUSH_READ = 3'd6,
        FLUSH_WB   = 3'd7
    } state_t;

endpackage
